/* src.f */
hdl/udp_pkg.sv
hdl/input_arbiter.sv
hdl/output_port_lookup.sv
hdl/output_queues.sv
hdl/udp_reg_master.sv
hdl/user_data_path.sv
tb/tb_user_data_path.sv

/* Bender.yml */
package:
  name: user_data_path

sources:
  # Design, package first
  - hdl/udp_pkg.sv
  - hdl/input_arbiter.sv
  - hdl/output_port_lookup.sv
  - hdl/output_queues.sv
  - hdl/udp_reg_master.sv
  - hdl/user_data_path.sv
  # Testbench
  - target: test
    files:
      - tb/tb_user_data_path.sv

/* tb/tb_user_data_path.sv */
// ****************************************
// Testbench for the user data path. Drives
// packets from a table into the four input
// ports under random output stalls, checks
// every word per output port and runs the
// register accesses of a second table.
// ****************************************
`timescale 1ns/1ps

module tb_user_data_path;

   localparam int NUM_PKTS      = 21;
   localparam int NUM_REGS      = 17;
   localparam int DRAIN_TIMEOUT = 4000;
   localparam int ACK_TIMEOUT   = 20;
   localparam int ACK_CYCLES    = 4;

   // One packet with phase, input port, dst, length in words and expected output port
   typedef struct packed {
      logic       phase;
      logic [1:0] src;
      logic [7:0] dst;
      logic [7:0] len;
      logic [1:0] oport;
   } pkt_case_t;

   // One register access with phase, read flag, address, write data and expected read data
   typedef struct packed {
      logic                               phase;
      logic                               rd;
      logic [udp_pkg::REG_ADDR_WIDTH-1:0] addr;
      logic [udp_pkg::REG_DATA_WIDTH-1:0] wdata;
      logic [udp_pkg::REG_DATA_WIDTH-1:0] rdata;
   } reg_case_t;

   localparam pkt_case_t PKT_TABLE [NUM_PKTS] = '{
      // Identity port map
      '{1'b0, 2'd0, 8'h00, 8'd2,  2'd0},
      '{1'b0, 2'd1, 8'h02, 8'd4,  2'd2},
      '{1'b0, 2'd2, 8'h01, 8'd3,  2'd1},
      '{1'b0, 2'd3, 8'h03, 8'd5,  2'd3},
      '{1'b0, 2'd0, 8'h03, 8'd6,  2'd3},
      '{1'b0, 2'd1, 8'h01, 8'd2,  2'd1},
      '{1'b0, 2'd2, 8'h02, 8'd8,  2'd2},
      '{1'b0, 2'd3, 8'h00, 8'd3,  2'd0},
      '{1'b0, 2'd0, 8'h06, 8'd4,  2'd2},
      // Long packets from all inputs to port 0 fill its FIFO
      '{1'b0, 2'd0, 8'h00, 8'd12, 2'd0},
      '{1'b0, 2'd1, 8'h00, 8'd12, 2'd0},
      '{1'b0, 2'd2, 8'h00, 8'd12, 2'd0},
      '{1'b0, 2'd3, 8'h00, 8'd12, 2'd0},
      // Map 0->3, 1->2, 2->0, 3->1
      '{1'b1, 2'd0, 8'h00, 8'd3,  2'd3},
      '{1'b1, 2'd1, 8'h01, 8'd4,  2'd2},
      '{1'b1, 2'd2, 8'h02, 8'd5,  2'd0},
      '{1'b1, 2'd3, 8'h03, 8'd2,  2'd1},
      '{1'b1, 2'd1, 8'h00, 8'd7,  2'd3},
      '{1'b1, 2'd2, 8'h0D, 8'd3,  2'd2},
      '{1'b1, 2'd3, 8'h02, 8'd6,  2'd0},
      '{1'b1, 2'd0, 8'h03, 8'd4,  2'd1}
   };

   localparam reg_case_t REG_TABLE [NUM_REGS] = '{
      // Remap the lookup block, then read the entries back
      '{1'b0, 1'b0, 12'h100, 32'd3, 32'd0},
      '{1'b0, 1'b0, 12'h101, 32'd2, 32'd0},
      '{1'b0, 1'b0, 12'h102, 32'd0, 32'd0},
      '{1'b0, 1'b0, 12'h103, 32'd1, 32'd0},
      '{1'b0, 1'b1, 12'h100, 32'd0, 32'd3},
      '{1'b0, 1'b1, 12'h101, 32'd0, 32'd2},
      '{1'b0, 1'b1, 12'h102, 32'd0, 32'd0},
      '{1'b0, 1'b1, 12'h103, 32'd0, 32'd1},
      // Sent counters after all traffic
      '{1'b1, 1'b1, 12'h200, 32'd0, 32'd8},
      '{1'b1, 1'b1, 12'h201, 32'd0, 32'd4},
      '{1'b1, 1'b1, 12'h202, 32'd0, 32'd5},
      '{1'b1, 1'b1, 12'h203, 32'd0, 32'd4},
      // Counter write has no effect
      '{1'b1, 1'b0, 12'h201, 32'h55, 32'd0},
      '{1'b1, 1'b1, 12'h201, 32'd0, 32'd4},
      // Nobody claims these
      '{1'b1, 1'b1, 12'h300, 32'd0, udp_pkg::REG_NO_ACK_DATA},
      '{1'b1, 1'b1, 12'h104, 32'd0, udp_pkg::REG_NO_ACK_DATA},
      '{1'b1, 1'b1, 12'h000, 32'd0, udp_pkg::REG_NO_ACK_DATA}
   };

   logic                                  clk;
   logic                                  rst_n;
   udp_pkg::pkt_word_t                    in_data  [udp_pkg::NUM_PORTS];
   logic                                  in_wr    [udp_pkg::NUM_PORTS];
   logic                                  in_rdy   [udp_pkg::NUM_PORTS];
   udp_pkg::pkt_word_t                    out_data [udp_pkg::NUM_PORTS];
   logic                                  out_wr   [udp_pkg::NUM_PORTS];
   logic                                  out_rdy  [udp_pkg::NUM_PORTS];
   logic                                  reg_req;
   logic                                  reg_rd_wr_l;
   logic [udp_pkg::REG_ADDR_WIDTH-1:0]    reg_addr;
   logic [udp_pkg::REG_DATA_WIDTH-1:0]    reg_wr_data;
   logic                                  reg_ack;
   logic [udp_pkg::REG_DATA_WIDTH-1:0]    reg_rd_data;

   // Words still to send per input and expected words per input/output pair
   udp_pkg::pkt_word_t                    src_q [udp_pkg::NUM_PORTS][$];
   udp_pkg::pkt_word_t                    exp_q [udp_pkg::NUM_PORTS*udp_pkg::NUM_PORTS][$];
   logic                                  want    [udp_pkg::NUM_PORTS];
   logic                                  taken   [udp_pkg::NUM_PORTS];
   logic                                  in_pkt  [udp_pkg::NUM_PORTS];
   logic [udp_pkg::PORT_BITS-1:0]         cur_src [udp_pkg::NUM_PORTS];
   int                                    seed = 88177;

   user_data_path user_data_path_inst (
      .clk         (clk),
      .rst_n       (rst_n),
      .in_data     (in_data),
      .in_wr       (in_wr),
      .in_rdy      (in_rdy),
      .out_data    (out_data),
      .out_wr      (out_wr),
      .out_rdy     (out_rdy),
      .reg_req     (reg_req),
      .reg_rd_wr_l (reg_rd_wr_l),
      .reg_addr    (reg_addr),
      .reg_wr_data (reg_wr_data),
      .reg_ack     (reg_ack),
      .reg_rd_data (reg_rd_data)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // ****************************************
   // Checks
   // ****************************************
   task automatic fail_run(input string msg);
      $display("%s", msg);
      $display("Checks failed");
      $fatal(1);
   endtask

   task automatic check_word(input string name, input udp_pkg::pkt_word_t got,
                             input udp_pkg::pkt_word_t expected);
      if (got !== expected) begin
         fail_run($sformatf("Mismatch %s: got %h expected %h", name, got, expected));
      end
   endtask

   task automatic check_reg(input string name,
                            input logic [udp_pkg::REG_DATA_WIDTH-1:0] got,
                            input logic [udp_pkg::REG_DATA_WIDTH-1:0] expected);
      if (got !== expected) begin
         fail_run($sformatf("Mismatch %s: got %h expected %h", name, got, expected));
      end
   endtask

   task automatic check_cycles(input string name, input int got, input int expected);
      if (got != expected) begin
         fail_run($sformatf("Mismatch %s: got %0h expected %0h", name, got, expected));
      end
   endtask

   // Number of input ports that currently see rdy
   function automatic int ready_ports();
      int n;
      n = 0;
      for (int p = 0; p < udp_pkg::NUM_PORTS; p++) begin
         if (in_rdy[p]) begin
            n++;
         end
      end
      return n;
   endfunction

   // ****************************************
   // Packet stimulus and scoreboard
   // ****************************************

   // Source id sits in the low byte of rsvd so the monitor can find its queue
   task automatic queue_packet(input pkt_case_t c, input int idx);
      udp_pkg::pkt_hdr_t  hdr;
      udp_pkg::pkt_word_t w;
      int                 q;
      q         = c.src * udp_pkg::NUM_PORTS + c.oport;
      hdr.oport = '0;
      hdr.rsvd  = {32'h5A5A_0000, 8'(idx), 8'(c.src)};
      hdr.dst   = c.dst;
      w.ctrl    = udp_pkg::HDR_CTRL;
      w.data    = hdr;
      src_q[c.src].push_back(w);
      // Lookup sets oport to the one-hot of the mapped port
      hdr.oport = 8'(1) << c.oport;
      w.data    = hdr;
      exp_q[q].push_back(w);
      for (int k = 1; k < c.len; k++) begin
         w.ctrl = (k == c.len - 1) ? c.len : 8'h00;
         w.data = {8'(idx), 8'(c.src), 16'(k), 32'(idx * 977 + k)};
         src_q[c.src].push_back(w);
         exp_q[q].push_back(w);
      end
   endtask

   task automatic take_word(input int o, input udp_pkg::pkt_word_t w);
      udp_pkg::pkt_hdr_t  hdr;
      udp_pkg::pkt_word_t expected;
      int                 q;
      hdr = udp_pkg::pkt_hdr_t'(w.data);
      if (w.ctrl == udp_pkg::HDR_CTRL) begin
         if (in_pkt[o]) begin
            fail_run($sformatf("Header on output %0d before the previous packet ended", o));
         end
         cur_src[o] = hdr.rsvd[udp_pkg::PORT_BITS-1:0];
         in_pkt[o]  = 1'b1;
      end else if (!in_pkt[o]) begin
         fail_run($sformatf("Word on output %0d outside of any packet", o));
      end
      q = cur_src[o] * udp_pkg::NUM_PORTS + o;
      if (exp_q[q].size() == 0) begin
         fail_run($sformatf("Unexpected word on output %0d from input %0d", o, cur_src[o]));
      end
      expected = exp_q[q].pop_front();
      check_word($sformatf("out_data[%0d]", o), w, expected);
      if (w.ctrl != '0 && w.ctrl != udp_pkg::HDR_CTRL) begin
         in_pkt[o] = 1'b0;
      end
   endtask

   function automatic logic all_empty();
      logic empty;
      empty = 1'b1;
      for (int i = 0; i < udp_pkg::NUM_PORTS; i++) begin
         if (src_q[i].size() != 0) begin
            empty = 1'b0;
         end
      end
      for (int i = 0; i < udp_pkg::NUM_PORTS * udp_pkg::NUM_PORTS; i++) begin
         if (exp_q[i].size() != 0) begin
            empty = 1'b0;
         end
      end
      return empty;
   endfunction

   task automatic wait_drained();
      int cycles;
      cycles = 0;
      while (!all_empty()) begin
         @(negedge clk);
         cycles++;
         if (cycles > DRAIN_TIMEOUT) begin
            fail_run("Timeout while waiting for all packets to leave the outputs");
         end
      end
   endtask

   task automatic run_packets(input logic ph);
      @(negedge clk);
      for (int i = 0; i < NUM_PKTS; i++) begin
         if (PKT_TABLE[i].phase == ph) begin
            queue_packet(PKT_TABLE[i], i);
         end
      end
      wait_drained();
   endtask

   // A port raises wr only while the arbiter gives it rdy
   always_comb begin
      for (int p = 0; p < udp_pkg::NUM_PORTS; p++) begin
         in_wr[p] = want[p] && in_rdy[p];
      end
   end

   // Next word goes out once the previous one was taken
   always @(posedge clk) begin
      for (int p = 0; p < udp_pkg::NUM_PORTS; p++) begin
         if (taken[p]) begin
            void'(src_q[p].pop_front());
         end
         if (src_q[p].size() != 0) begin
            in_data[p] <= src_q[p][0];
            want[p]    <= 1'b1;
         end else begin
            in_data[p] <= '0;
            want[p]    <= 1'b0;
         end
      end
   end

   // Random stalls on every output
   always @(posedge clk) begin
      for (int p = 0; p < udp_pkg::NUM_PORTS; p++) begin
         out_rdy[p] <= (($random(seed) & 1) == 1);
      end
   end

   // Handshakes are stable mid cycle and complete at the next rising edge
   always @(negedge clk) begin
      for (int p = 0; p < udp_pkg::NUM_PORTS; p++) begin
         taken[p] = in_wr[p];
      end
      if (rst_n) begin
         if (ready_ports() > 1) begin
            fail_run("More than one input port sees rdy at the same time");
         end
         for (int o = 0; o < udp_pkg::NUM_PORTS; o++) begin
            if (out_wr[o]) begin
               take_word(o, out_data[o]);
            end
         end
      end
   end

   // ****************************************
   // Register accesses
   // ****************************************
   task automatic reg_access(input reg_case_t op);
      int cycles;
      @(posedge clk);
      reg_req     <= 1'b1;
      reg_rd_wr_l <= op.rd;
      reg_addr    <= op.addr;
      reg_wr_data <= op.wdata;
      @(posedge clk);
      reg_req <= 1'b0;
      cycles = 1;
      @(negedge clk);
      while (!reg_ack) begin
         cycles++;
         if (cycles > ACK_TIMEOUT) begin
            fail_run($sformatf("Timeout while waiting for reg_ack at address %h", op.addr));
         end
         @(negedge clk);
      end
      check_cycles("reg_ack latency", cycles, ACK_CYCLES);
      if (op.rd) begin
         check_reg($sformatf("reg_rd_data at %h", op.addr), reg_rd_data, op.rdata);
      end
   endtask

   task automatic run_regs(input logic ph);
      for (int i = 0; i < NUM_REGS; i++) begin
         if (REG_TABLE[i].phase == ph) begin
            reg_access(REG_TABLE[i]);
         end
      end
   endtask

   initial begin
      rst_n       = 1'b0;
      reg_req     = 1'b0;
      reg_rd_wr_l = 1'b0;
      reg_addr    = '0;
      reg_wr_data = '0;
      for (int p = 0; p < udp_pkg::NUM_PORTS; p++) begin
         in_data[p] = '0;
         want[p]    = 1'b0;
         taken[p]   = 1'b0;
         out_rdy[p] = 1'b0;
         in_pkt[p]  = 1'b0;
         cur_src[p] = '0;
      end
      repeat (3) @(posedge clk);
      rst_n <= 1'b1;

      run_packets(1'b0);
      run_regs(1'b0);
      run_packets(1'b1);
      run_regs(1'b1);

      $display("All checks passed");
      $finish;
   end

endmodule

/* hdl/user_data_path.sv */
// ****************************************
// User data path top. Arbiter, lookup and
// output queues in a line, with the register
// master closing the ring through lookup
// and queues.
// ****************************************
`timescale 1ns/1ps

module user_data_path (
   input  logic                                  clk,
   input  logic                                  rst_n,
   input  udp_pkg::pkt_word_t                    in_data  [udp_pkg::NUM_PORTS],
   input  logic                                  in_wr    [udp_pkg::NUM_PORTS],
   output logic                                  in_rdy   [udp_pkg::NUM_PORTS],
   output udp_pkg::pkt_word_t                    out_data [udp_pkg::NUM_PORTS],
   output logic                                  out_wr   [udp_pkg::NUM_PORTS],
   input  logic                                  out_rdy  [udp_pkg::NUM_PORTS],
   input  logic                                  reg_req,
   input  logic                                  reg_rd_wr_l,
   input  logic [udp_pkg::REG_ADDR_WIDTH-1:0]    reg_addr,
   input  logic [udp_pkg::REG_DATA_WIDTH-1:0]    reg_wr_data,
   output logic                                  reg_ack,
   output logic [udp_pkg::REG_DATA_WIDTH-1:0]    reg_rd_data
);

   // Arbiter to lookup
   udp_pkg::pkt_word_t   arb_data;
   logic                 arb_wr;
   logic                 arb_rdy;

   // Lookup to queues
   udp_pkg::pkt_word_t   lut_data;
   logic                 lut_wr;
   logic                 lut_rdy;

   // Ring hops, master to lookup to queues to master
   udp_pkg::reg_ring_t   ring_m2l;
   udp_pkg::reg_ring_t   ring_l2q;
   udp_pkg::reg_ring_t   ring_q2m;

   input_arbiter input_arbiter_inst (
      .clk      (clk),
      .rst_n    (rst_n),
      .in_data  (in_data),
      .in_wr    (in_wr),
      .in_rdy   (in_rdy),
      .out_data (arb_data),
      .out_wr   (arb_wr),
      .out_rdy  (arb_rdy)
   );

   output_port_lookup output_port_lookup_inst (
      .clk      (clk),
      .rst_n    (rst_n),
      .in_data  (arb_data),
      .in_wr    (arb_wr),
      .in_rdy   (arb_rdy),
      .out_data (lut_data),
      .out_wr   (lut_wr),
      .out_rdy  (lut_rdy),
      .ring_in  (ring_m2l),
      .ring_out (ring_l2q)
   );

   output_queues output_queues_inst (
      .clk      (clk),
      .rst_n    (rst_n),
      .in_data  (lut_data),
      .in_wr    (lut_wr),
      .in_rdy   (lut_rdy),
      .out_data (out_data),
      .out_wr   (out_wr),
      .out_rdy  (out_rdy),
      .ring_in  (ring_l2q),
      .ring_out (ring_q2m)
   );

   udp_reg_master udp_reg_master_inst (
      .clk         (clk),
      .rst_n       (rst_n),
      .reg_req     (reg_req),
      .reg_rd_wr_l (reg_rd_wr_l),
      .reg_addr    (reg_addr),
      .reg_wr_data (reg_wr_data),
      .reg_ack     (reg_ack),
      .reg_rd_data (reg_rd_data),
      .ring_out    (ring_m2l),
      .ring_in     (ring_q2m)
   );

endmodule

/* hdl/udp_reg_master.sv */
// ****************************************
// Register master. Turns each host access
// into one request on the ring and returns
// the reply, or the no-ack word if no
// block claimed the address.
// ****************************************
`timescale 1ns/1ps

module udp_reg_master (
   input  logic                                  clk,
   input  logic                                  rst_n,
   input  logic                                  reg_req,
   input  logic                                  reg_rd_wr_l,
   input  logic [udp_pkg::REG_ADDR_WIDTH-1:0]    reg_addr,
   input  logic [udp_pkg::REG_DATA_WIDTH-1:0]    reg_wr_data,
   output logic                                  reg_ack,
   output logic [udp_pkg::REG_DATA_WIDTH-1:0]    reg_rd_data,
   output udp_pkg::reg_ring_t                    ring_out,
   input  udp_pkg::reg_ring_t                    ring_in
);

   // High from launch until the request comes back around
   logic pending;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         ring_out <= '0;
         pending  <= 1'b0;
         reg_ack  <= 1'b0;
      end else begin
         ring_out.req <= 1'b0;
         if (reg_req && !pending) begin
            ring_out.req     <= 1'b1;
            ring_out.ack     <= 1'b0;
            ring_out.rd_wr_l <= reg_rd_wr_l;
            ring_out.addr    <= reg_addr;
            ring_out.data    <= reg_wr_data;
            pending          <= 1'b1;
         end else if (ring_in.req) begin
            pending <= 1'b0;
         end
         reg_ack <= ring_in.req && pending;
      end
   end

   // Unclaimed accesses read back the fixed no-ack word
   always_ff @(posedge clk) begin
      if (ring_in.req) begin
         reg_rd_data <= ring_in.ack ? ring_in.data : udp_pkg::REG_NO_ACK_DATA;
      end
   end

   // Lookup and queues each hold the request one cycle
   a_ring_latency: assert property (@(posedge clk) disable iff (!rst_n)
      ring_out.req |-> ##2 ring_in.req);

endmodule

/* hdl/output_queues.sv */
// ****************************************
// Output queues. Each packet is steered by
// its header oport into one of four word
// FIFOs that drain to the output ports.
// Sent packets are counted per port and
// read back over the register ring.
// ****************************************
`timescale 1ns/1ps

module output_queues (
   input  logic                clk,
   input  logic                rst_n,
   input  udp_pkg::pkt_word_t  in_data,
   input  logic                in_wr,
   output logic                in_rdy,
   output udp_pkg::pkt_word_t  out_data [udp_pkg::NUM_PORTS],
   output logic                out_wr   [udp_pkg::NUM_PORTS],
   input  logic                out_rdy  [udp_pkg::NUM_PORTS],
   input  udp_pkg::reg_ring_t  ring_in,
   output udp_pkg::reg_ring_t  ring_out
);

   logic [udp_pkg::NUM_PORTS-1:0]        full;
   logic [udp_pkg::NUM_PORTS-1:0]        fifo_wr;
   logic [udp_pkg::REG_DATA_WIDTH-1:0]   sent_cnt [udp_pkg::NUM_PORTS];
   logic [udp_pkg::PORT_BITS-1:0]        hdr_port;
   logic [udp_pkg::PORT_BITS-1:0]        cur_port;
   logic [udp_pkg::PORT_BITS-1:0]        wr_port;
   logic                                 is_hdr;
   logic                                 reg_hit;

   // One-hot oport of the header to a queue index
   always_comb begin
      udp_pkg::pkt_hdr_t hdr;
      hdr      = udp_pkg::pkt_hdr_t'(in_data.data);
      hdr_port = '0;
      for (int i = 0; i < udp_pkg::NUM_PORTS; i++) begin
         if (hdr.oport[i]) begin
            hdr_port = udp_pkg::PORT_BITS'(i);
         end
      end
   end

   assign is_hdr  = (in_data.ctrl == udp_pkg::HDR_CTRL);
   assign wr_port = is_hdr ? hdr_port : cur_port;
   assign in_rdy  = ~|full;

   // Body words follow the queue chosen by their header
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         cur_port <= '0;
      end else if (in_wr && is_hdr) begin
         cur_port <= hdr_port;
      end
   end

   // ****************************************
   // Per-port FIFO and sent counter
   // ****************************************
   for (genvar p = 0; p < udp_pkg::NUM_PORTS; p++) begin : g_q
      udp_pkg::pkt_word_t                  mem [udp_pkg::OQ_DEPTH];
      logic [udp_pkg::OQ_ADDR_WIDTH-1:0]   wr_ptr;
      logic [udp_pkg::OQ_ADDR_WIDTH-1:0]   rd_ptr;
      logic [udp_pkg::OQ_ADDR_WIDTH:0]     count;
      logic                                rd_en;

      assign fifo_wr[p]  = in_wr && (wr_port == p);
      assign full[p]     = (count == udp_pkg::OQ_DEPTH);
      assign rd_en       = out_rdy[p] && (count != '0);
      assign out_wr[p]   = rd_en;
      assign out_data[p] = mem[rd_ptr];

      always_ff @(posedge clk) begin
         if (fifo_wr[p]) begin
            mem[wr_ptr] <= in_data;
         end
      end

      always_ff @(posedge clk) begin
         if (!rst_n) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            count       <= '0;
            sent_cnt[p] <= '0;
         end else begin
            if (fifo_wr[p]) wr_ptr <= wr_ptr + 1'b1;
            if (rd_en) rd_ptr <= rd_ptr + 1'b1;
            case ({fifo_wr[p], rd_en})
               2'b10:   count <= count + 1'b1;
               2'b01:   count <= count - 1'b1;
               default: count <= count;
            endcase
            if (rd_en && udp_pkg::is_last(mem[rd_ptr])) begin
               sent_cnt[p] <= sent_cnt[p] + 1'b1;
            end
         end
      end

      a_no_wr_full: assert property (@(posedge clk) disable iff (!rst_n)
         fifo_wr[p] |-> !full[p]);
   end

   // ****************************************
   // Ring node, counters at offsets 0-3
   // ****************************************
   assign reg_hit = ring_in.req &&
      (ring_in.addr[udp_pkg::REG_ADDR_WIDTH-1 -: udp_pkg::REG_BLK_WIDTH] == udp_pkg::BLK_OQ) &&
      (ring_in.addr[udp_pkg::REG_OFS_WIDTH-1:0] < udp_pkg::NUM_PORTS);

   // Counters are read only, a write is acked and dropped
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         ring_out <= '0;
      end else begin
         ring_out <= ring_in;
         if (reg_hit) begin
            ring_out.ack <= 1'b1;
            if (ring_in.rd_wr_l) begin
               ring_out.data <= sent_cnt[ring_in.addr[udp_pkg::PORT_BITS-1:0]];
            end
         end
      end
   end

endmodule

/* hdl/output_port_lookup.sv */
// ****************************************
// Output port lookup. Header words get a
// one-hot oport from a programmable port
// map indexed by dst, other words pass as
// they are. Also a node on the register ring.
// ****************************************
`timescale 1ns/1ps

module output_port_lookup (
   input  logic                clk,
   input  logic                rst_n,
   input  udp_pkg::pkt_word_t  in_data,
   input  logic                in_wr,
   output logic                in_rdy,
   output udp_pkg::pkt_word_t  out_data,
   output logic                out_wr,
   input  logic                out_rdy,
   input  udp_pkg::reg_ring_t  ring_in,
   output udp_pkg::reg_ring_t  ring_out
);

   logic [udp_pkg::PORT_BITS-1:0]     port_map [udp_pkg::NUM_PORTS];
   udp_pkg::pkt_hdr_t                 in_hdr;
   logic [7:0]                        oport_oh;
   udp_pkg::pkt_word_t                lut_word;
   logic                              out_vld;
   logic                              reg_hit;
   logic [udp_pkg::PORT_BITS-1:0]     reg_idx;

   // ****************************************
   // Header rewrite
   // ****************************************
   always_comb begin
      in_hdr   = udp_pkg::pkt_hdr_t'(in_data.data);
      oport_oh = '0;
      oport_oh[port_map[in_hdr.dst[udp_pkg::PORT_BITS-1:0]]] = 1'b1;
      lut_word = in_data;
      if (in_data.ctrl == udp_pkg::HDR_CTRL) begin
         in_hdr.oport  = oport_oh;
         lut_word.data = in_hdr;
      end
   end

   assign in_rdy = out_rdy;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         out_vld <= 1'b0;
      end else if (out_rdy) begin
         out_vld <= in_wr;
      end
   end

   always_ff @(posedge clk) begin
      if (out_rdy) begin
         out_data <= lut_word;
      end
   end

   assign out_wr  = out_vld && out_rdy;

   // ****************************************
   // Ring node with the map entries at offsets 0 to 3
   // ****************************************
   assign reg_hit = ring_in.req &&
      (ring_in.addr[udp_pkg::REG_ADDR_WIDTH-1 -: udp_pkg::REG_BLK_WIDTH] == udp_pkg::BLK_LOOKUP) &&
      (ring_in.addr[udp_pkg::REG_OFS_WIDTH-1:0] < udp_pkg::NUM_PORTS);
   assign reg_idx = ring_in.addr[udp_pkg::PORT_BITS-1:0];

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         ring_out <= '0;
         // Identity map out of reset
         for (int i = 0; i < udp_pkg::NUM_PORTS; i++) begin
            port_map[i] <= udp_pkg::PORT_BITS'(i);
         end
      end else begin
         ring_out <= ring_in;
         if (reg_hit) begin
            ring_out.ack <= 1'b1;
            if (ring_in.rd_wr_l) begin
               ring_out.data <= udp_pkg::REG_DATA_WIDTH'(port_map[reg_idx]);
            end else begin
               port_map[reg_idx] <= ring_in.data[udp_pkg::PORT_BITS-1:0];
            end
         end
      end
   end

   // The upstream stage must not push a word while stalled
   a_wr_needs_rdy: assert property (@(posedge clk) disable iff (!rst_n)
      in_wr |-> in_rdy);

endmodule

/* hdl/input_arbiter.sv */
// ****************************************
// Packet-granular round-robin arbiter that
// merges the four input ports into one
// registered stream. A port is granted
// when it presents a header word.
// ****************************************
`timescale 1ns/1ps

module input_arbiter (
   input  logic                clk,
   input  logic                rst_n,
   input  udp_pkg::pkt_word_t  in_data [udp_pkg::NUM_PORTS],
   input  logic                in_wr   [udp_pkg::NUM_PORTS],
   output logic                in_rdy  [udp_pkg::NUM_PORTS],
   output udp_pkg::pkt_word_t  out_data,
   output logic                out_wr,
   input  logic                out_rdy
);

   udp_pkg::arb_state_e                state;
   logic [udp_pkg::PORT_BITS-1:0]      grant;
   logic [udp_pkg::PORT_BITS-1:0]      nxt_port;
   logic                               nxt_found;
   udp_pkg::pkt_word_t                 sel_word;
   logic                               sel_wr;
   logic                               out_vld;

   // ****************************************
   // Round-robin search
   // ****************************************

   // Start one port after the last grant so every port gets its turn
   always_comb begin
      logic [udp_pkg::PORT_BITS-1:0] idx;
      nxt_port  = grant;
      nxt_found = 1'b0;
      for (int k = 1; k <= udp_pkg::NUM_PORTS; k++) begin
         idx = grant + k[udp_pkg::PORT_BITS-1:0];
         if (!nxt_found && in_data[idx].ctrl == udp_pkg::HDR_CTRL) begin
            nxt_port  = idx;
            nxt_found = 1'b1;
         end
      end
   end

   assign sel_word = in_data[grant];
   assign sel_wr   = in_wr[grant] && (state == udp_pkg::ARB_XFER);

   // Only the granted port may send
   always_comb begin
      for (int i = 0; i < udp_pkg::NUM_PORTS; i++) begin
         in_rdy[i] = 1'b0;
      end
      if (state == udp_pkg::ARB_XFER) begin
         in_rdy[grant] = out_rdy;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state <= udp_pkg::ARB_IDLE;
         grant <= udp_pkg::PORT_BITS'(udp_pkg::NUM_PORTS - 1);
      end else begin
         case (state)
            udp_pkg::ARB_IDLE: begin
               if (nxt_found) begin
                  grant <= nxt_port;
                  state <= udp_pkg::ARB_XFER;
               end
            end
            udp_pkg::ARB_XFER: begin
               // Release once the last word is taken
               if (sel_wr && udp_pkg::is_last(sel_word)) begin
                  state <= udp_pkg::ARB_IDLE;
               end
            end
            default: state <= udp_pkg::ARB_IDLE;
         endcase
      end
   end

   // ****************************************
   // Output register
   // ****************************************
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         out_vld <= 1'b0;
      end else if (out_rdy) begin
         out_vld <= sel_wr;
      end
   end

   always_ff @(posedge clk) begin
      if (out_rdy) begin
         out_data <= sel_word;
      end
   end

   assign out_wr = out_vld && out_rdy;

   // A word written without rdy would be dropped
   for (genvar i = 0; i < udp_pkg::NUM_PORTS; i++) begin : g_wr_chk
      a_wr_needs_rdy: assert property (@(posedge clk) disable iff (!rst_n)
         in_wr[i] |-> in_rdy[i]);
   end

endmodule

/* hdl/udp_pkg.sv */
// ****************************************
// Shared widths, packet and register ring
// types, the register address map and the
// enums of the user data path. Every block
// refers to these by scoped name.
// ****************************************

package udp_pkg;

   // Packet stream
   localparam int DATA_WIDTH = 64;
   localparam int CTRL_WIDTH = 8;
   localparam int NUM_PORTS  = 4;
   localparam int PORT_BITS  = $clog2(NUM_PORTS);

   // Header word marker, zero marks a body word, anything else ends a packet
   localparam logic [CTRL_WIDTH-1:0] HDR_CTRL = '1;

   // Register ring
   localparam int REG_ADDR_WIDTH = 12;
   localparam int REG_BLK_WIDTH  = 4;
   localparam int REG_OFS_WIDTH  = 8;
   localparam int REG_DATA_WIDTH = 32;
   localparam logic [REG_DATA_WIDTH-1:0] REG_NO_ACK_DATA = 32'hDEADBEEF;

   // Output queues
   localparam int OQ_DEPTH      = 16;
   localparam int OQ_ADDR_WIDTH = $clog2(OQ_DEPTH);

   typedef struct packed {
      logic [CTRL_WIDTH-1:0] ctrl;
      logic [DATA_WIDTH-1:0] data;
   } pkt_word_t;

   // Overlay of the data word of a header
   typedef struct packed {
      logic [7:0]            oport;
      logic [DATA_WIDTH-17:0] rsvd;
      logic [7:0]            dst;
   } pkt_hdr_t;

   typedef struct packed {
      logic                      req;
      logic                      ack;
      logic                      rd_wr_l;
      logic [REG_ADDR_WIDTH-1:0] addr;
      logic [REG_DATA_WIDTH-1:0] data;
   } reg_ring_t;

   // Block field in the top bits of a ring address
   typedef enum logic [REG_BLK_WIDTH-1:0] {
      BLK_LOOKUP = 4'd1,
      BLK_OQ     = 4'd2
   } reg_block_e;

   typedef enum logic {
      ARB_IDLE,
      ARB_XFER
   } arb_state_e;

   // True for the closing word of a packet
   function automatic logic is_last(input pkt_word_t w);
      return (w.ctrl != '0) && (w.ctrl != HDR_CTRL);
   endfunction

endpackage
